// ==== flist.f ====
+incdir+hdl
hdl/frame_switch_pkg.sv
hdl/axis_if.sv
hdl/frame_dispatch.sv
hdl/frame_fifo.sv
hdl/frame_arbiter.sv
hdl/frame_switch.sv
test/frame_switch_sva.sv
test/frame_switch_tb.sv

// ==== hdl/axis_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axis_if import frame_switch_pkg::*; ();

  data_t tdata;
  logic  tvalid;
  logic  tready;
  logic  tlast;
  logic  tuser;   // Error flag, meaningful on the last beat

  modport source (
    output tdata, tvalid, tlast, tuser,
    input  tready
  );

  modport sink (
    input  tdata, tvalid, tlast, tuser,
    output tready
  );

endinterface

`default_nettype wire

// ==== hdl/frame_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_arbiter import frame_switch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  axis_if.sink  lanes [`FS_LANES],
  output data_t out_data,
  output logic  out_valid,
  output logic  out_last,
  output lane_t out_lane,
  input  logic  out_ready
);

  arb_state_t state;
  lane_t      grant;
  lane_t      rr_ptr;   // First lane to look at next time
  lane_t      pick;
  logic       pick_ok;
  logic       out_free;
  logic       beat_mv;

  logic [`FS_LANES-1:0] lane_valid;
  logic [`FS_LANES-1:0] lane_last;
  data_t                lane_data [`FS_LANES];

  assign out_free = out_ready || !out_valid;
  assign beat_mv  = (state == ARB_FRAME) && out_free && lane_valid[grant];

  genvar i;
  generate
    for (i = 0; i < `FS_LANES; i++) begin : gen_lane
      assign lane_valid[i]  = lanes[i].tvalid;
      assign lane_last[i]   = lanes[i].tlast;
      assign lane_data[i]   = lanes[i].tdata;
      assign lanes[i].tready = (state == ARB_FRAME) && (grant == lane_t'(i)) && out_free;
    end
  endgenerate

  // Round-robin search starting at rr_ptr
  always_comb begin
    int idx;
    idx     = 0;
    pick    = rr_ptr;
    pick_ok = 1'b0;
    for (int k = 0; k < `FS_LANES; k++) begin
      idx = (int'(rr_ptr) + k) % `FS_LANES;
      if (!pick_ok && lane_valid[idx]) begin
        pick    = lane_t'(idx);
        pick_ok = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ARB_IDLE;
      grant     <= '0;
      rr_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: if (pick_ok) begin
          state  <= ARB_FRAME;
          grant  <= pick;
          rr_ptr <= (pick == lane_t'(`FS_LANES - 1)) ? lane_t'(0) : pick + 1'b1;
        end
        ARB_FRAME: if (beat_mv && lane_last[grant]) begin
          state <= ARB_IDLE;   // Frame done
        end
        default: state <= ARB_IDLE;
      endcase
      if (out_free) begin
        out_valid <= beat_mv;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_mv) begin
      out_data <= lane_data[grant];
      out_last <= lane_last[grant];
      out_lane <= grant;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frame_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_dispatch import frame_switch_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  data_t        in_data,
  input  logic         in_valid,
  input  logic         in_last,
  input  logic         in_user,
  input  logic         in_first,
  input  lane_t        in_lane,
  axis_if.source       lanes [`FS_LANES]
);

  lane_t cur_lane;   // Lane of the frame in flight
  lane_t sel_lane;
  logic  first_beat;

  assign first_beat = in_valid && in_first;

  // First beat routes on its own lane field right away
  assign sel_lane = first_beat ? in_lane : cur_lane;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_lane <= '0;
    end else if (first_beat) begin
      cur_lane <= in_lane;
    end
  end

  // Lanes never stall, so tready is not consulted here
  genvar i;
  generate
    for (i = 0; i < `FS_LANES; i++) begin : gen_route
      assign lanes[i].tvalid = in_valid && (sel_lane == lane_t'(i));
      assign lanes[i].tdata  = in_data;
      assign lanes[i].tlast  = in_last;
      assign lanes[i].tuser  = in_user;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_fifo import frame_switch_pkg::*; #(
  parameter int ADDR_W = `FS_ADDR_W
) (
  input  logic  clk,
  input  logic  rst,
  axis_if.sink  s,
  axis_if.source m,
  output logic  drop
);

  localparam int DEPTH = 2 ** ADDR_W;

  // Each entry is {last, data}
  logic [$bits(data_t):0] mem [DEPTH];

  logic [ADDR_W:0] wr_ptr;       // Committed, end of last good frame
  logic [ADDR_W:0] wr_ptr_cur;   // Next free entry of the frame in progress
  logic [ADDR_W:0] rd_ptr;

  logic  dropping;   // Frame overflowed, discard until last
  logic  full;
  logic  empty;
  logic  wr_beat;
  logic  store;
  logic  rd_en;
  logic  out_valid;
  data_t out_data;
  logic  out_last;

  assign full  = (wr_ptr_cur[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr_cur[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);   // Nothing committed left to read

  assign s.tready = 1'b1;   // Drop when full
  assign wr_beat  = s.tvalid && s.tready;
  assign store    = wr_beat && !full && !dropping;

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr_cur[ADDR_W-1:0]] <= {s.tlast, s.tdata};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      dropping   <= 1'b0;
      drop       <= 1'b0;
    end else begin
      drop <= 1'b0;
      if (wr_beat) begin
        if (full || dropping) begin
          if (s.tlast) begin
            wr_ptr_cur <= wr_ptr;   // Rewind the partial frame
            dropping   <= 1'b0;
            drop       <= 1'b1;
          end else begin
            dropping <= 1'b1;
          end
        end else if (s.tlast) begin
          if (s.tuser) begin
            wr_ptr_cur <= wr_ptr;
            drop       <= 1'b1;
          end else begin
            wr_ptr     <= wr_ptr_cur + 1'b1;   // Publish the frame
            wr_ptr_cur <= wr_ptr_cur + 1'b1;
          end
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
        end
      end
    end
  end

  // One-beat output register
  assign rd_en = (m.tready || !out_valid) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (m.tready || !out_valid) begin
        out_valid <= !empty;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      {out_last, out_data} <= mem[rd_ptr[ADDR_W-1:0]];
    end
  end

  assign m.tvalid = out_valid;
  assign m.tdata  = out_data;
  assign m.tlast  = out_last;
  assign m.tuser  = 1'b0;   // Only clean frames get out

endmodule

`default_nettype wire

// ==== hdl/frame_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_switch import frame_switch_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  data_t                in_data,
  input  logic                 in_valid,
  input  logic                 in_last,
  input  logic                 in_user,
  input  logic                 in_first,
  input  lane_t                in_lane,
  output data_t                out_data,
  output logic                 out_valid,
  output logic                 out_last,
  output lane_t                out_lane,
  input  logic                 out_ready,
  output logic [`FS_LANES-1:0] drop
);

  axis_if lane_in  [`FS_LANES] ();   // Dispatcher to FIFOs
  axis_if lane_out [`FS_LANES] ();   // FIFOs to arbiter

  frame_dispatch u_dispatch (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_last  (in_last),
    .in_user  (in_user),
    .in_first (in_first),
    .in_lane  (in_lane),
    .lanes    (lane_in)
  );

  genvar g;
  generate
    for (g = 0; g < `FS_LANES; g++) begin : gen_lane
      frame_fifo #(
        .ADDR_W (`FS_ADDR_W)
      ) u_fifo (
        .clk  (clk),
        .rst  (rst),
        .s    (lane_in[g]),
        .m    (lane_out[g]),
        .drop (drop[g])
      );
    end
  endgenerate

  frame_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .lanes     (lane_out),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_lane  (out_lane),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== hdl/frame_switch_params.svh ====
`ifndef FRAME_SWITCH_PARAMS_SVH
`define FRAME_SWITCH_PARAMS_SVH

// Number of FIFO lanes behind the dispatcher
`define FS_LANES 4

// Width of one stream beat
`define FS_DATA_W 8

// Lane FIFO address width, 2**FS_ADDR_W entries per lane
`define FS_ADDR_W 4

`endif

// ==== hdl/frame_switch_pkg.sv ====
`default_nettype none

`include "frame_switch_params.svh"

package frame_switch_pkg;

  // One data beat
  typedef logic [`FS_DATA_W-1:0] data_t;

  // Lane index
  typedef logic [$clog2(`FS_LANES)-1:0] lane_t;

  // FIFO pointer with wrap bit
  typedef logic [`FS_ADDR_W:0] ptr_t;

  typedef enum logic {
    ARB_IDLE,   // Looking for a lane with a frame
    ARB_FRAME   // Forwarding the granted frame
  } arb_state_t;

endpackage

`default_nettype wire

// ==== test/frame_switch_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_switch_sva import frame_switch_pkg::*; (
  input logic                 clk,
  input logic                 rst,
  input data_t                out_data,
  input logic                 out_valid,
  input logic                 out_last,
  input lane_t                out_lane,
  input logic                 out_ready,
  input logic [`FS_LANES-1:0] drop
);

  property p_out_hold;
    @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=>
        out_valid && $stable(out_data) && $stable(out_last) && $stable(out_lane);
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("Output beat changed while out_ready was low");

  a_rst_idle: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during reset");

  genvar i;
  generate
    for (i = 0; i < `FS_LANES; i++) begin : gen_chk
      logic [`FS_ADDR_W:0] used;

      // Committed beats not yet taken by the lane output register
      assign used = gen_lane[i].u_fifo.wr_ptr - gen_lane[i].u_fifo.rd_ptr;

      a_drop_pulse: assert property (@(posedge clk) disable iff (rst) drop[i] |=> !drop[i])
        else $error("Drop pulse on lane %0d lasted two cycles", i);

      // Reading past the committed pointer wraps used above the depth
      a_read_bound: assert property (@(posedge clk) disable iff (rst)
                                     used <= 2 ** `FS_ADDR_W)
        else $error("Lane %0d read beyond its committed data", i);
    end
  endgenerate

endmodule

bind frame_switch frame_switch_sva u_sva (.*);

`default_nettype wire

// ==== test/frame_switch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_switch_params.svh"

module frame_switch_tb import frame_switch_pkg::*; ();

  localparam int QDEPTH  = 64;
  localparam int TIMEOUT = 2000;

  logic                 clk;
  logic                 rst;
  data_t                in_data;
  logic                 in_valid;
  logic                 in_last;
  logic                 in_user;
  logic                 in_first;
  lane_t                in_lane;
  data_t                out_data;
  logic                 out_valid;
  logic                 out_last;
  lane_t                out_lane;
  logic                 out_ready;
  logic [`FS_LANES-1:0] drop;

  logic [31:0] lfsr;
  logic        hold_low;   // Stall window from the data file
  int          value_errs;
  int          other_errs;

  // Per-lane rings of expected beats
  data_t exp_data  [`FS_LANES][QDEPTH];
  logic  exp_last  [`FS_LANES][QDEPTH];
  int    exp_wr    [`FS_LANES];
  int    exp_rd    [`FS_LANES];
  int    exp_drops [`FS_LANES];
  int    seen_drops[`FS_LANES];

  data_t frm_data [QDEPTH];   // Frame being driven
  int    frm_len;
  lane_t frm_lane;
  logic  in_frame;            // Output is inside a frame
  lane_t frame_lane;

  frame_switch u_frame_switch (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // Step to the drive point of the next cycle and update the stall
  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (hold_low) begin
      out_ready = 1'b0;
    end else begin
      out_ready = lfsr[0];
      lfsr      = lfsr_step(lfsr);
    end
  endtask

  task automatic idle_inputs();
    in_valid = 1'b0;
    in_data  = '0;
    in_last  = 1'b0;
    in_user  = 1'b0;
    in_first = 1'b0;
    in_lane  = '0;
  endtask

  task automatic close_frame(input logic drop_exp);
    if (drop_exp) begin
      exp_drops[frm_lane]++;
    end else begin
      for (int k = 0; k < frm_len; k++) begin
        exp_data[frm_lane][exp_wr[frm_lane] % QDEPTH] = frm_data[k];
        exp_last[frm_lane][exp_wr[frm_lane] % QDEPTH] = (k == frm_len - 1);
        exp_wr[frm_lane]++;
      end
    end
    frm_len = 0;
  endtask

  task automatic run_file();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v, l, d, t, u, x, s;
    logic        first;
    fd = $fopen("test/frame_switch_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      other_errs++;
      return;
    end
    first = 1'b1;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      n = $sscanf(line, "%h %h %h %h %h %h %h", v, l, d, t, u, x, s);
      if (n != 7) continue;   // Comment or blank line
      hold_low = s[0];
      next_cycle();
      in_valid = v[0];
      in_data  = data_t'(d);
      in_lane  = lane_t'(l);
      in_last  = t[0];
      in_user  = u[0];
      in_first = v[0] && first;
      if (v[0]) begin
        if (first) frm_lane = lane_t'(l);
        if (frm_len < QDEPTH) begin
          frm_data[frm_len] = data_t'(d);
          frm_len++;
        end
        if (t[0]) close_frame(x[0]);
        first = t[0];
      end
    end
    $fclose(fd);
    hold_low = 1'b0;
    next_cycle();
    idle_inputs();
  endtask

  function automatic logic pending();
    for (int i = 0; i < `FS_LANES; i++) begin
      if (exp_rd[i] != exp_wr[i]) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic drain();
    int waited;
    waited = 0;
    while ((pending() || out_valid) && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (waited >= TIMEOUT) begin
      $display("Timed out waiting for the expected output beats");
      other_errs++;
    end
    repeat (8) next_cycle();
  endtask

  task automatic check_beat();
    lane_t ln;
    int    idx;
    ln = out_lane;
    if (exp_rd[ln] == exp_wr[ln]) begin
      $display("Unexpected beat %h on lane %0d at %0t", out_data, ln, $time);
      other_errs++;
    end else begin
      idx = exp_rd[ln] % QDEPTH;
      check_data("out_data", exp_data[ln][idx], out_data);
      check_flag("out_last", exp_last[ln][idx], out_last);
      exp_rd[ln]++;
    end
    if (in_frame) begin
      check_lane("out_lane", frame_lane, out_lane);   // No interleaving inside a frame
    end else begin
      frame_lane = out_lane;
    end
    in_frame = !out_last;
  endtask

  // Mid-cycle sampling, beat moves at the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `FS_LANES; i++) begin
        if (drop[i]) seen_drops[i]++;
      end
      if (out_valid && out_ready) check_beat();
    end
  end

  initial begin
    rst        = 1'b1;
    out_ready  = 1'b0;
    hold_low   = 1'b0;
    lfsr       = 32'hecf0_f08b;
    value_errs = 0;
    other_errs = 0;
    frm_len    = 0;
    frm_lane   = '0;
    in_frame   = 1'b0;
    frame_lane = '0;
    idle_inputs();
    for (int i = 0; i < `FS_LANES; i++) begin
      exp_wr[i]     = 0;
      exp_rd[i]     = 0;
      exp_drops[i]  = 0;
      seen_drops[i] = 0;
    end
    repeat (16) next_cycle();
    rst = 1'b0;
    run_file();
    drain();
    for (int i = 0; i < `FS_LANES; i++) begin
      check_count($sformatf("drop count lane %0d", i), exp_drops[i], seen_drops[i]);
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/frame_switch_testdata.txt ====
// valid lane data last user drop stall, all hex, one input beat per line
// drop is the expected drop flag on last beats, stall holds out_ready low
1 0 01 0 0 0 0
1 0 02 0 0 0 0
1 0 03 1 0 0 0
1 1 11 0 0 0 0
1 1 12 1 0 0 0
1 2 21 0 0 0 0
1 2 22 1 0 0 0
1 3 31 0 0 0 0
1 3 32 1 0 0 0
0 0 00 0 0 0 0
1 1 13 0 0 0 0
1 1 14 1 1 1 0
0 0 00 0 0 0 0
1 1 15 0 0 0 0
1 1 16 1 0 0 0
0 0 00 0 0 0 0
1 2 80 0 0 0 0
1 2 81 0 0 0 0
1 2 82 0 0 0 0
1 2 83 0 0 0 0
1 2 84 0 0 0 0
1 2 85 0 0 0 0
1 2 86 0 0 0 0
1 2 87 0 0 0 0
1 2 88 0 0 0 0
1 2 89 0 0 0 0
1 2 8a 0 0 0 0
1 2 8b 0 0 0 0
1 2 8c 0 0 0 0
1 2 8d 0 0 0 0
1 2 8e 0 0 0 0
1 2 8f 0 0 0 0
1 2 90 1 0 1 0
1 2 23 0 0 0 0
1 2 24 1 0 0 0
0 0 00 0 0 0 1
1 0 04 0 0 0 1
1 0 05 1 0 0 1
1 3 33 0 0 0 1
1 3 34 0 0 0 1
1 3 35 1 0 0 1
1 0 06 1 0 0 1
0 0 00 0 0 0 1
0 0 00 0 0 0 0
1 2 25 0 0 0 0
1 2 26 1 0 0 0
